// ==== filelist.f ====
src/fir_types_pkg.sv
src/fir_coeff_pkg.sv
src/tap_delay_line.sv
src/tap_product_stage.sv
src/partial_sum_tree.sv
src/fir_output_stage.sv
src/fir_top.sv
verification/fir_assert.sv
verification/fir_tb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Build and run the FIR filter testbench with Verilator.
set -e

cd "$(dirname "$0")"

log=sim.log

verilator --binary --timing --assert -j 0 \
	--top-module fir_tb \
	-f filelist.f \
	-o fir_sim

status=0
./obj_dir/fir_sim > "$log" 2>&1 || status=$?
cat "$log"

if grep -q "Test failures found" "$log"; then
	echo "simulation failed, see $log"
	exit 1
fi

if [ "$status" -ne 0 ]; then
	echo "simulator exited with status $status"
	exit 1
fi

echo "simulation finished without failures"

// ==== src/fir_coeff_pkg.sv ====
/*
 * FIR configuration
 * tap counts, symmetric coefficient table and pipeline depth
 */

`default_nettype none

package fir_coeff_pkg;

	// tap counts follow the vector types
	localparam int NUM_TAPS = $bits(fir_types_pkg::tap_vec_t) / fir_types_pkg::SAMPLE_W;
	localparam int NUM_UNIQ = (NUM_TAPS + 1) / 2;

	// products handled by each partial-sum tree
	localparam int HALF_UNIQ = $bits(fir_types_pkg::product_vec_t) / fir_types_pkg::SAMPLE_W;

	// unique coefficients, entry k serves taps k and NUM_TAPS-1-k
	// last entry is the center tap
	localparam fir_types_pkg::sample_t COEFFS [NUM_UNIQ] = '{
		88, 0, -97, -197, -294, -380,
		-447, -490, -504, -481, -420, -319
	};

	// enabled edges from i_in to o_out
	// delay line 1, pre-add 1, multiply 1, tree 3, final add 1
	localparam int PIPE_LATENCY = 7;

endpackage

`default_nettype wire

// ==== src/fir_output_stage.sv ====
/*
 * FIR output stage
 * joins the two partial sums and delays the valid strobe to match
 */

`default_nettype none

module fir_output_stage (
	input  wire                           clk,
	input  wire                           reset,
	input  wire                           i_clk_ena,
	input  wire                           i_valid,
	input  fir_types_pkg::partial_sums_t  i_sums,
	output fir_types_pkg::sample_t        o_out,
	output logic                          o_valid
);

	fir_types_pkg::sample_t out_reg;

	// bit 0 is the newest strobe
	logic [fir_coeff_pkg::PIPE_LATENCY-1:0] valid_sr;

	// ********************
	// final adder
	// ********************

	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			out_reg <= '0;
		end else if (i_clk_ena) begin
			out_reg <= i_sums.low_sum + i_sums.high_sum;
		end
	end

	// ********************
	// valid delay
	// ********************

	// same depth as the data path, frozen by the same enable
	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			valid_sr <= '0;
		end else if (i_clk_ena) begin
			valid_sr <= {valid_sr[fir_coeff_pkg::PIPE_LATENCY-2:0], i_valid};
		end
	end

	assign o_out   = out_reg;
	assign o_valid = valid_sr[fir_coeff_pkg::PIPE_LATENCY-1];

endmodule

`default_nettype wire

// ==== src/fir_top.sv ====
/*
 * 23-tap symmetric FIR filter, top level
 * delay line, pre-add and multiply, two adder trees, output stage
 */

`default_nettype none

module fir_top (
	input  wire                     clk,
	input  wire                     reset,
	input  wire                     i_clk_ena,
	input  wire                     i_valid,
	input  fir_types_pkg::sample_t  i_in,
	output logic                    o_valid,
	output fir_types_pkg::sample_t  o_out
);

	fir_types_pkg::tap_vec_t       taps;
	fir_types_pkg::product_vec_t   low_products;
	fir_types_pkg::product_vec_t   high_products;
	fir_types_pkg::sample_t        low_sum;
	fir_types_pkg::sample_t        high_sum;
	fir_types_pkg::partial_sums_t  sums;

	tap_delay_line u_delay_line (
		.clk       (clk),
		.reset     (reset),
		.i_clk_ena (i_clk_ena),
		.i_in      (i_in),
		.o_taps    (taps)
	);

	tap_product_stage u_product_stage (
		.clk             (clk),
		.reset           (reset),
		.i_clk_ena       (i_clk_ena),
		.i_taps          (taps),
		.o_low_products  (low_products),
		.o_high_products (high_products)
	);

	// ********************
	// adder trees
	// ********************

	partial_sum_tree u_low_tree (
		.clk        (clk),
		.reset      (reset),
		.i_clk_ena  (i_clk_ena),
		.i_products (low_products),
		.o_sum      (low_sum)
	);

	partial_sum_tree u_high_tree (
		.clk        (clk),
		.reset      (reset),
		.i_clk_ena  (i_clk_ena),
		.i_products (high_products),
		.o_sum      (high_sum)
	);

	assign sums.low_sum  = low_sum;
	assign sums.high_sum = high_sum;

	// valid enters here and skips the datapath
	fir_output_stage u_output_stage (
		.clk       (clk),
		.reset     (reset),
		.i_clk_ena (i_clk_ena),
		.i_valid   (i_valid),
		.i_sums    (sums),
		.o_out     (o_out),
		.o_valid   (o_valid)
	);

endmodule

`default_nettype wire

// ==== src/fir_types_pkg.sv ====
/*
 * FIR data formats
 * sample word, tap and product vectors, and the pair of partial sums
 */

`default_nettype none

package fir_types_pkg;

	// ********************
	// sample format
	// ********************

	// all arithmetic in the filter wraps at this width
	localparam int SAMPLE_W = 18;

	typedef logic signed [SAMPLE_W-1:0] sample_t;

	// ********************
	// vectors
	// ********************

	// contents of the delay line, index 0 is the newest sample
	typedef sample_t [22:0] tap_vec_t;

	// one half of the coefficient products
	typedef sample_t [5:0] product_vec_t;

	// results of the low and high adder trees
	typedef struct packed {
		sample_t high_sum;
		sample_t low_sum;
	} partial_sums_t;

endpackage

`default_nettype wire

// ==== src/partial_sum_tree.sv ====
/*
 * Partial-sum tree
 * three registered levels reduce six products to one wrapping sum
 */

`default_nettype none

module partial_sum_tree (
	input  wire                          clk,
	input  wire                          reset,
	input  wire                          i_clk_ena,
	input  fir_types_pkg::product_vec_t  i_products,
	output fir_types_pkg::sample_t       o_sum
);

	// level 1, pairwise sums of the products
	fir_types_pkg::sample_t [fir_coeff_pkg::HALF_UNIQ/2-1:0] level1;

	// level 2, one sum and one bye
	fir_types_pkg::sample_t [1:0] level2;

	// level 3, the tree result
	fir_types_pkg::sample_t sum_reg;

	// ********************
	// level 1
	// ********************

	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			level1 <= '0;
		end else if (i_clk_ena) begin
			for (int i = 0; i < fir_coeff_pkg::HALF_UNIQ / 2; i++) begin
				level1[i] <= i_products[2*i] + i_products[2*i+1];
			end
		end
	end

	// ********************
	// levels 2 and 3
	// ********************

	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			level2  <= '0;
			sum_reg <= '0;
		end else if (i_clk_ena) begin
			level2[0] <= level1[0] + level1[1];
			// odd element waits one edge so both paths line up
			level2[1] <= level1[2];
			sum_reg   <= level2[0] + level2[1];
		end
	end

	assign o_sum = sum_reg;

endmodule

`default_nettype wire

// ==== src/tap_delay_line.sv ====
/*
 * Tap delay line
 * keeps the last 23 input samples, shifting on every enabled edge
 */

`default_nettype none

module tap_delay_line (
	input  wire                      clk,
	input  wire                      reset,
	input  wire                      i_clk_ena,
	input  fir_types_pkg::sample_t   i_in,
	output fir_types_pkg::tap_vec_t  o_taps
);

	// tap 0 holds the newest sample
	fir_types_pkg::tap_vec_t tap_reg;

	// ********************
	// shift register
	// ********************

	// advances whether or not the sample is strobed valid
	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			tap_reg <= '0;
		end else if (i_clk_ena) begin
			tap_reg <= {tap_reg[fir_coeff_pkg::NUM_TAPS-2:0], i_in};
		end
	end

	assign o_taps = tap_reg;

endmodule

`default_nettype wire

// ==== src/tap_product_stage.sv ====
/*
 * Symmetric pre-add and coefficient multiply
 * folds tap k with tap 22-k, then scales each fold by its coefficient
 */

`default_nettype none

module tap_product_stage (
	input  wire                          clk,
	input  wire                          reset,
	input  wire                          i_clk_ena,
	input  fir_types_pkg::tap_vec_t      i_taps,
	output fir_types_pkg::product_vec_t  o_low_products,
	output fir_types_pkg::product_vec_t  o_high_products
);

	// folded tap pairs, last entry is the center tap alone
	fir_types_pkg::sample_t [fir_coeff_pkg::NUM_UNIQ-1:0] folded;

	// low 18 bits of each coefficient product
	fir_types_pkg::sample_t [fir_coeff_pkg::NUM_UNIQ-1:0] products;

	// ********************
	// pre-adders
	// ********************

	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			folded <= '0;
		end else if (i_clk_ena) begin
			for (int k = 0; k < fir_coeff_pkg::NUM_UNIQ - 1; k++) begin
				folded[k] <= i_taps[k] + i_taps[fir_coeff_pkg::NUM_TAPS-1-k];
			end
			// center tap has no partner, passes with the same delay
			folded[fir_coeff_pkg::NUM_UNIQ-1] <= i_taps[fir_coeff_pkg::NUM_UNIQ-1];
		end
	end

	// ********************
	// multipliers
	// ********************

	// product wraps to the sample width, as the rest of the datapath
	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			products <= '0;
		end else if (i_clk_ena) begin
			for (int k = 0; k < fir_coeff_pkg::NUM_UNIQ; k++) begin
				products[k] <= folded[k] * fir_coeff_pkg::COEFFS[k];
			end
		end
	end

	// products 0..5 to the low tree, 6..11 to the high tree
	assign o_low_products  = products[fir_coeff_pkg::HALF_UNIQ-1:0];
	assign o_high_products = products[fir_coeff_pkg::NUM_UNIQ-1:fir_coeff_pkg::HALF_UNIQ];

endmodule

`default_nettype wire

// ==== verification/fir_assert.sv ====
/*
 * FIR output assertions
 * reset clears the strobe, outputs hold while the clock enable is low
 */

`default_nettype none

module fir_assert (
	input wire                     clk,
	input wire                     reset,
	input wire                     i_clk_ena,
	input wire                     i_dut_valid,
	input fir_types_pkg::sample_t  i_dut_out
);
	timeunit 1ns;
	timeprecision 1ps;

	// no strobe while the pipeline is cleared
	a_valid_low_in_reset: assert property (@(posedge clk) reset |-> !i_dut_valid)
		else $error("o_valid high during reset");

	// ********************
	// enable hold
	// ********************

	a_out_hold: assert property (@(posedge clk) disable iff (reset)
		!i_clk_ena |=> $stable(i_dut_out))
		else $error("o_out changed after an edge with clock enable low");

	a_valid_hold: assert property (@(posedge clk) disable iff (reset)
		!i_clk_ena |=> $stable(i_dut_valid))
		else $error("o_valid changed after an edge with clock enable low");

endmodule

bind fir_top fir_assert u_assert (
	.clk         (clk),
	.reset       (reset),
	.i_clk_ena   (i_clk_ena),
	.i_dut_valid (o_valid),
	.i_dut_out   (o_out)
);

`default_nettype wire

// ==== verification/fir_tb.sv ====
/*
 * FIR filter testbench
 * LFSR stimulus against a symmetric FIR model, impulse, enable, valid and reset tests
 */

`default_nettype none

module fir_tb;
	timeunit 1ns;
	timeprecision 1ps;

	logic                    clk;
	logic                    reset;
	logic                    i_clk_ena;
	logic                    i_valid;
	fir_types_pkg::sample_t  i_in;
	logic                    o_valid;
	fir_types_pkg::sample_t  o_out;

	// filter coefficients by distance from the nearer end of the delay line
	int ref_coeffs [12] = '{
		88, 0, -97, -197, -294, -380,
		-447, -490, -504, -481, -420, -319
	};

	logic [31:0] lfsr_state = 32'h6112;

	// ********************
	// model state
	// ********************

	fir_types_pkg::sample_t  hist [fir_coeff_pkg::NUM_TAPS];
	fir_types_pkg::sample_t  pipe_out [fir_coeff_pkg::PIPE_LATENCY];
	logic                    pipe_valid [fir_coeff_pkg::PIPE_LATENCY];
	fir_types_pkg::sample_t  prev_out;
	logic                    prev_valid;
	logic                    run_complete = 1'b0;

	fir_top i_dut (
		.clk       (clk),
		.reset     (reset),
		.i_clk_ena (i_clk_ena),
		.i_valid   (i_valid),
		.i_in      (i_in),
		.o_valid   (o_valid),
		.o_out     (o_out)
	);

	initial begin
		clk = 1'b0;
		forever #4 clk = ~clk;
	end

	// x^32 + x^22 + x^2 + x + 1 stepped once per bit
	function automatic logic [31:0] take_bits(input int n);
		logic [31:0] r;
		logic        fb;
		r = '0;
		for (int i = 0; i < n; i++) begin
			fb = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
			lfsr_state = {lfsr_state[30:0], fb};
			r = {r[30:0], fb};
		end
		return r;
	endfunction

	task automatic check_value(input string name, input logic [31:0] got,
			input logic [31:0] exp);
		if (got !== exp) begin
			$display("[FAIL] %s: got 0x%h, expected 0x%h", name, got, exp);
			$display("Test failures found");
			$fatal(1);
		end
	endtask

	task automatic timeout_fail(input string what);
		$display("timeout while waiting for %s", what);
		$display("Test failures found");
		$fatal(1);
	endtask

	function automatic void model_clear();
		for (int k = 0; k < fir_coeff_pkg::NUM_TAPS; k++) begin
			hist[k] = '0;
		end
		for (int k = 0; k < fir_coeff_pkg::PIPE_LATENCY; k++) begin
			pipe_out[k]   = '0;
			pipe_valid[k] = 1'b0;
		end
	endfunction

	// one enabled edge shifts the history, sums it and feeds the latency queue
	function automatic void model_step(input fir_types_pkg::sample_t din, input logic vld);
		longint acc;
		int     c;
		for (int k = fir_coeff_pkg::NUM_TAPS - 1; k > 0; k--) begin
			hist[k] = hist[k-1];
		end
		hist[0] = din;
		acc = 0;
		for (int k = 0; k < fir_coeff_pkg::NUM_TAPS; k++) begin
			c = (k < 22 - k) ? k : 22 - k;
			acc = acc + longint'(ref_coeffs[c]) * longint'(hist[k]);
		end
		for (int k = fir_coeff_pkg::PIPE_LATENCY - 1; k > 0; k--) begin
			pipe_out[k]   = pipe_out[k-1];
			pipe_valid[k] = pipe_valid[k-1];
		end
		pipe_out[0]   = fir_types_pkg::sample_t'(acc);
		pipe_valid[0] = vld;
	endfunction

	// ********************
	// per-cycle drive and check
	// ********************

	task automatic drive_cycle(input logic rst, input logic ena, input logic vld,
			input fir_types_pkg::sample_t din);
		logic was_held;
		@(posedge clk);
		// inputs still hold the values the DUT samples on this edge
		was_held = !reset && !i_clk_ena && !rst;
		if (reset) begin
			model_clear();
		end else if (i_clk_ena) begin
			model_step(i_in, i_valid);
		end
		reset     <= rst;
		i_clk_ena <= ena;
		i_valid   <= vld;
		i_in      <= din;
		if (rst) begin
			model_clear();
		end
		@(negedge clk);
		if (was_held) begin
			check_value("o_out hold", 32'(o_out), 32'(prev_out));
			check_value("o_valid hold", 32'(o_valid), 32'(prev_valid));
		end
		check_value("o_out", 32'(o_out), 32'(pipe_out[fir_coeff_pkg::PIPE_LATENCY-1]));
		check_value("o_valid", 32'(o_valid), 32'(pipe_valid[fir_coeff_pkg::PIPE_LATENCY-1]));
		prev_out   = o_out;
		prev_valid = o_valid;
	endtask

	task automatic apply_reset();
		repeat (5) drive_cycle(1'b1, 1'b0, 1'b0, '0);
	endtask

	// gate_ena and gap_valid drop the enable or the strobe a quarter of the time
	task automatic run_random(input int cycles, input logic gate_ena, input logic gap_valid);
		logic [31:0]             r;
		logic                    ena;
		logic                    vld;
		fir_types_pkg::sample_t  din;
		for (int n = 0; n < cycles; n++) begin
			r = take_bits(2);
			ena = !gate_ena || (r[1:0] != 2'b00);
			r = take_bits(2);
			vld = !gap_valid || (r[1:0] != 2'b00);
			r = take_bits(3);
			if (r[2:0] == 3'd0) begin
				din = 18'h1ffff;
			end else if (r[2:0] == 3'd1) begin
				din = 18'h20000;
			end else begin
				din = fir_types_pkg::sample_t'(take_bits(18));
			end
			drive_cycle(1'b0, ena, vld, din);
		end
	endtask

	initial begin
		int   wait_count;
		logic got_valid;
		reset     <= 1'b1;
		i_clk_ena <= 1'b0;
		i_valid   <= 1'b0;
		i_in      <= '0;
		model_clear();
		prev_out   = '0;
		prev_valid = 1'b0;
		apply_reset();

		// pipeline empty after reset
		repeat (10) begin
			drive_cycle(1'b0, 1'b1, 1'b0, '0);
			check_value("o_out after reset", 32'(o_out), 32'd0);
			check_value("o_valid after reset", 32'(o_valid), 32'd0);
		end

		// ********************
		// impulse response
		// ********************
		drive_cycle(1'b0, 1'b1, 1'b1, 18'sd1);
		wait_count = 0;
		got_valid  = 1'b0;
		while (!got_valid) begin
			drive_cycle(1'b0, 1'b1, 1'b0, '0);
			wait_count++;
			if (o_valid) begin
				got_valid = 1'b1;
			end else if (wait_count >= 20) begin
				timeout_fail("o_valid after the impulse");
			end
		end
		// seven enabled edges from strobe to output
		check_value("impulse latency", 32'(wait_count), 32'd7);
		for (int k = 0; k < fir_coeff_pkg::NUM_TAPS; k++) begin
			if (k > 0) begin
				drive_cycle(1'b0, 1'b1, 1'b0, '0);
			end
			check_value("impulse o_out", 32'(o_out), 32'(ref_coeffs[(k < 22 - k) ? k : 22 - k]));
		end

		// random streams
		run_random(600, 1'b0, 1'b0);
		run_random(600, 1'b1, 1'b0);
		run_random(600, 1'b0, 1'b1);
		run_random(600, 1'b1, 1'b1);

		// reset while samples are in flight
		run_random(50, 1'b1, 1'b1);
		apply_reset();
		run_random(300, 1'b1, 1'b1);

		run_complete = 1'b1;
		$display("All tests passed!");
		$finish;
	end

	// run ended before the last test
	final begin
		if (!run_complete) begin
			$display("Test failures found");
		end
	end

endmodule

`default_nettype wire
